// ==== logic/qs_srt_pkg.sv ====
package qs_srt_pkg;

  // Array geometry
  localparam int N = 16;
  // Initial hi index handed to quicksort
  localparam int REG_N = N - 1;
  localparam int word_w = 16;
  localparam int addr_w = $clog2(N);
  localparam int STACK_DEPTH = 128;

  // Data word, index or register value
  typedef logic [word_w-1:0] word_t;
  typedef logic [addr_w-1:0] addr_t;
  // Microcode address
  typedef logic [7:0] pc_t;
  typedef logic [15:0] inst_t;
  typedef logic [3:0] op_t;
  typedef logic [2:0] reg_t;
  typedef logic [2:0] imm_t;
  typedef logic [1:0] cc_t;
  // One spare bit so a full stack is distinct from an empty one
  typedef logic [$clog2(STACK_DEPTH):0] sp_t;

  // Register names, BLINK holds the return address
  localparam reg_t R0 = 3'd0;
  localparam reg_t R1 = 3'd1;
  localparam reg_t R2 = 3'd2;
  localparam reg_t R3 = 3'd3;
  localparam reg_t R4 = 3'd4;
  localparam reg_t R5 = 3'd5;
  localparam reg_t R6 = 3'd6;
  localparam reg_t BLINK = 3'd7;

  // Opcodes in inst[15:12]
  localparam op_t OP_NOP = 4'h0;
  localparam op_t OP_J = 4'h1;
  localparam op_t OP_PUSHPOP = 4'h2;
  localparam op_t OP_LDST = 4'h4;
  localparam op_t OP_MOV = 4'h6;
  localparam op_t OP_ADDSUB = 4'h7;
  localparam op_t OP_CALLRET = 4'hC;
  localparam op_t OP_WAITEMIT = 4'hF;

  // Jump conditions in inst[9:8]
  localparam cc_t AL = 2'd0;
  localparam cc_t EQ = 2'd1;
  localparam cc_t GT = 2'd2;
  localparam cc_t LE = 2'd3;

  // MOVS special sources
  localparam imm_t SPC_REG_N = 3'd0;
  localparam imm_t SPC_N = 3'd1;

  // Routine entry points in the control store
  localparam pc_t SYM_RESET = 8'd0;
  localparam pc_t SYM_PARTITION = 8'd32;
  localparam pc_t SYM_QUICKSORT = 8'd64;
  localparam pc_t SYM_START = 8'd96;
  localparam pc_t SYM_ERR = 8'd128;

  // Engine request into the data array, one cycle per access
  typedef struct packed {
    logic en;
    logic wr;
    addr_t addr;
    word_t data;
  } mem_req_t;

  typedef enum logic [1:0] {
    EXE_RUN,
    EXE_AWAIT,
    EXE_HALT
  } exe_state_t;

  // Instruction encoders
  function automatic inst_t j(pc_t addr, cc_t cc = AL);
    return {OP_J, 2'b00, cc, addr};
  endfunction

  function automatic inst_t push(reg_t src);
    return {OP_PUSHPOP, 1'b0, 3'b000, 4'h0, 1'b0, src};
  endfunction

  function automatic inst_t pop(reg_t dst);
    return {OP_PUSHPOP, 1'b1, dst, 8'h00};
  endfunction

  // LD dst, [addr]
  function automatic inst_t ld(reg_t dst, reg_t addr);
    return {OP_LDST, 1'b0, dst, 5'b00000, addr};
  endfunction

  // ST [addr], src
  function automatic inst_t st(reg_t addr, reg_t src);
    return {OP_LDST, 1'b1, 3'b000, 1'b0, src, 1'b0, addr};
  endfunction

  function automatic inst_t mov(reg_t dst, reg_t src);
    return {OP_MOV, 1'b0, dst, 4'h0, 1'b0, src};
  endfunction

  function automatic inst_t movi(reg_t dst, imm_t imm);
    return {OP_MOV, 1'b0, dst, 4'h0, 1'b1, imm};
  endfunction

  function automatic inst_t movs(reg_t dst, imm_t sel);
    return {OP_MOV, 1'b1, dst, 5'b00000, sel};
  endfunction

  // With dst_en clear the result only sets the flags (.F form)
  function automatic inst_t add(reg_t dst, reg_t a, reg_t b, logic dst_en = 1'b1);
    return {OP_ADDSUB, 1'b0, dst, dst_en, a, 1'b0, b};
  endfunction

  function automatic inst_t addi(reg_t dst, reg_t a, imm_t imm, logic dst_en = 1'b1);
    return {OP_ADDSUB, 1'b0, dst, dst_en, a, 1'b1, imm};
  endfunction

  function automatic inst_t sub(reg_t dst, reg_t a, reg_t b, logic dst_en = 1'b1);
    return {OP_ADDSUB, 1'b1, dst, dst_en, a, 1'b0, b};
  endfunction

  function automatic inst_t subi(reg_t dst, reg_t a, imm_t imm, logic dst_en = 1'b1);
    return {OP_ADDSUB, 1'b1, dst, dst_en, a, 1'b1, imm};
  endfunction

  function automatic inst_t call(pc_t addr);
    return {OP_CALLRET, 1'b0, 3'b000, addr};
  endfunction

  function automatic inst_t ret();
    return {OP_CALLRET, 1'b1, 11'h000};
  endfunction

  function automatic inst_t await();
    return {OP_WAITEMIT, 1'b0, 11'h000};
  endfunction

  function automatic inst_t done();
    return {OP_WAITEMIT, 1'b1, 11'h000};
  endfunction

endpackage

// ==== logic/qs_srt_ucode_rom.sv ====
`timescale 1ns/1ns

module qs_srt_ucode_rom
  import qs_srt_pkg::*;
(
  input pc_t ra,
  output inst_t rout
);

  // Control store as a flat lookup, addressed straight from pc
  // Partition uses R0 lo, R1 hi, R2 pivot, R3 i, R4 j, R5/R6 temps
  // Partition returns the pivot index in R0 and clobbers R1
  always_comb begin
    case (ra)
      // Reset vector
      SYM_RESET: rout = j(SYM_START);

      // Partition, callee saves R2 to R6
      SYM_PARTITION: rout = push(R2);
      SYM_PARTITION + 8'd1: rout = push(R3);
      SYM_PARTITION + 8'd2: rout = push(R4);
      SYM_PARTITION + 8'd3: rout = push(R5);
      SYM_PARTITION + 8'd4: rout = push(R6);
      // Pivot is the last element, i and j start at lo
      SYM_PARTITION + 8'd5: rout = ld(R2, R1);
      SYM_PARTITION + 8'd6: rout = mov(R3, R0);
      SYM_PARTITION + 8'd7: rout = mov(R4, R0);
      // Loop head, leave once j reaches hi
      SYM_PARTITION + 8'd8: rout = sub(R0, R1, R4, 1'b0);
      SYM_PARTITION + 8'd9: rout = j(SYM_PARTITION + 8'd19, EQ);
      // Skip the swap when A[j] is above the pivot
      SYM_PARTITION + 8'd10: rout = ld(R5, R4);
      SYM_PARTITION + 8'd11: rout = sub(R0, R5, R2, 1'b0);
      SYM_PARTITION + 8'd12: rout = j(SYM_PARTITION + 8'd17, GT);
      // Swap A[i] and A[j], then bump i
      SYM_PARTITION + 8'd13: rout = ld(R6, R3);
      SYM_PARTITION + 8'd14: rout = st(R3, R5);
      SYM_PARTITION + 8'd15: rout = st(R4, R6);
      SYM_PARTITION + 8'd16: rout = addi(R3, R3, 3'd1);
      SYM_PARTITION + 8'd17: rout = addi(R4, R4, 3'd1);
      SYM_PARTITION + 8'd18: rout = j(SYM_PARTITION + 8'd8);
      // j equals hi here, so this swaps A[i] with the pivot
      SYM_PARTITION + 8'd19: rout = ld(R0, R3);
      SYM_PARTITION + 8'd20: rout = ld(R1, R4);
      SYM_PARTITION + 8'd21: rout = st(R3, R1);
      SYM_PARTITION + 8'd22: rout = st(R4, R0);
      SYM_PARTITION + 8'd23: rout = mov(R0, R3);
      SYM_PARTITION + 8'd24: rout = pop(R6);
      SYM_PARTITION + 8'd25: rout = pop(R5);
      SYM_PARTITION + 8'd26: rout = pop(R4);
      SYM_PARTITION + 8'd27: rout = pop(R3);
      SYM_PARTITION + 8'd28: rout = pop(R2);
      SYM_PARTITION + 8'd29: rout = ret();

      // Quicksort on [R0, R1], recursive so BLINK is saved too
      SYM_QUICKSORT: rout = push(BLINK);
      SYM_QUICKSORT + 8'd1: rout = push(R2);
      SYM_QUICKSORT + 8'd2: rout = push(R3);
      SYM_QUICKSORT + 8'd3: rout = push(R4);
      SYM_QUICKSORT + 8'd4: rout = mov(R2, R0);
      SYM_QUICKSORT + 8'd5: rout = mov(R4, R1);
      // Nothing to do when lo is past hi, hi may be lo minus one
      SYM_QUICKSORT + 8'd6: rout = sub(R0, R0, R1, 1'b0);
      SYM_QUICKSORT + 8'd7: rout = j(SYM_QUICKSORT + 8'd16, GT);
      SYM_QUICKSORT + 8'd8: rout = call(SYM_PARTITION);
      // Left half [lo, p - 1]
      SYM_QUICKSORT + 8'd9: rout = mov(R3, R0);
      SYM_QUICKSORT + 8'd10: rout = mov(R0, R2);
      SYM_QUICKSORT + 8'd11: rout = subi(R1, R3, 3'd1);
      SYM_QUICKSORT + 8'd12: rout = call(SYM_QUICKSORT);
      // Right half [p + 1, hi]
      SYM_QUICKSORT + 8'd13: rout = addi(R0, R3, 3'd1);
      SYM_QUICKSORT + 8'd14: rout = mov(R1, R4);
      SYM_QUICKSORT + 8'd15: rout = call(SYM_QUICKSORT);
      SYM_QUICKSORT + 8'd16: rout = pop(R4);
      SYM_QUICKSORT + 8'd17: rout = pop(R3);
      SYM_QUICKSORT + 8'd18: rout = pop(R2);
      SYM_QUICKSORT + 8'd19: rout = pop(BLINK);
      SYM_QUICKSORT + 8'd20: rout = ret();

      // Entry point, clear the register file once after reset
      SYM_START: rout = movi(R0, 3'd0);
      SYM_START + 8'd1: rout = movi(R1, 3'd0);
      SYM_START + 8'd2: rout = movi(R2, 3'd0);
      SYM_START + 8'd3: rout = movi(R3, 3'd0);
      SYM_START + 8'd4: rout = movi(R4, 3'd0);
      SYM_START + 8'd5: rout = movi(R5, 3'd0);
      SYM_START + 8'd6: rout = movi(R6, 3'd0);
      SYM_START + 8'd7: rout = movi(BLINK, 3'd0);
      // Idle here until the host pulses start
      SYM_START + 8'd8: rout = await();
      // Sort the whole array [0, N - 1]
      SYM_START + 8'd9: rout = movi(R0, 3'd0);
      SYM_START + 8'd10: rout = movs(R1, SPC_REG_N);
      SYM_START + 8'd11: rout = call(SYM_QUICKSORT);
      SYM_START + 8'd12: rout = done();
      SYM_START + 8'd13: rout = j(SYM_START + 8'd8);

      // Error trap, spins on itself
      SYM_ERR: rout = j(SYM_ERR);

      // Stray addresses fall into the trap
      default: rout = j(SYM_ERR);
    endcase
  end

endmodule

// ==== logic/qs_srt_exe.sv ====
`timescale 1ns/1ns

module qs_srt_exe
  import qs_srt_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input inst_t inst,
  output pc_t pc,
  output mem_req_t mem_req,
  input word_t mem_rdata,
  input logic start,
  output logic busy,
  output logic done
);

  exe_state_t state;
  word_t regs [8];
  word_t stack [STACK_DEPTH];
  sp_t sp;
  sp_t sp_m1;
  logic flag_eq;
  logic flag_gt;

  // Instruction fields
  op_t op;
  logic fn;
  reg_t rd;
  reg_t rs;
  reg_t ru;
  cc_t cc;
  logic use_imm;
  logic dst_en;
  pc_t tgt;

  logic exec;
  logic take;
  word_t opa;
  word_t opb;
  logic [word_w:0] res_x;
  word_t spc_val;
  pc_t pc_inc;
  pc_t pc_nxt;
  logic rf_we;
  reg_t rf_wa;
  word_t rf_wd;
  logic is_push;
  logic is_pop;

  // fn is bit 11, selecting pop, st, movs, sub, ret or done
  assign op = inst[15:12];
  assign fn = inst[11];
  assign rd = inst[10:8];
  assign cc = inst[9:8];
  assign dst_en = inst[7];
  assign rs = inst[6:4];
  assign use_imm = inst[3];
  assign ru = inst[2:0];
  assign tgt = inst[7:0];

  // Nothing executes outside RUN or at the error trap
  assign exec = (state == EXE_RUN) && (pc != SYM_ERR);
  assign is_push = exec && (op == OP_PUSHPOP) && !fn;
  assign is_pop = exec && (op == OP_PUSHPOP) && fn;
  assign sp_m1 = sp - 1'b1;
  assign pc_inc = pc + 8'd1;

  // ALU, one guard bit makes GT exact for signed operands
  assign opa = regs[rs];
  assign opb = use_imm ? word_t'(ru) : regs[ru];
  assign res_x = fn ? {opa[word_w-1], opa} - {opb[word_w-1], opb}
                    : {opa[word_w-1], opa} + {opb[word_w-1], opb};

  // MOVS sources
  always_comb begin
    case (ru)
      SPC_REG_N: spc_val = word_t'(REG_N);
      SPC_N: spc_val = word_t'(N);
      default: spc_val = '0;
    endcase
  end

  // LE is taken as not GT
  always_comb begin
    case (cc)
      AL: take = 1'b1;
      EQ: take = flag_eq;
      GT: take = flag_gt;
      default: take = !flag_gt;
    endcase
  end

  // Next pc, RET reads the low byte of BLINK
  always_comb begin
    pc_nxt = pc_inc;
    case (op)
      OP_J: if (take) pc_nxt = tgt;
      OP_CALLRET: pc_nxt = fn ? regs[BLINK][7:0] : tgt;
      default: ;
    endcase
  end

  // Single register write port
  always_comb begin
    rf_we = 1'b0;
    rf_wa = rd;
    rf_wd = res_x[word_w-1:0];
    if (exec) begin
      case (op)
        OP_PUSHPOP: begin
          rf_we = fn;
          rf_wd = stack[sp_m1[$bits(sp_t)-2:0]];
        end
        // LD writes the load data at the same edge
        OP_LDST: begin
          rf_we = !fn;
          rf_wd = mem_rdata;
        end
        OP_MOV: begin
          rf_we = 1'b1;
          if (fn) rf_wd = spc_val;
          else rf_wd = opb;
        end
        OP_ADDSUB: rf_we = dst_en;
        // CALL links the return address
        OP_CALLRET: begin
          rf_we = !fn;
          rf_wa = BLINK;
          rf_wd = word_t'(pc_inc);
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rf_we) regs[rf_wa] <= rf_wd;
    if (is_push) stack[sp[$bits(sp_t)-2:0]] <= regs[ru];
  end

  // Data array access, address comes from the low bits of a register
  assign mem_req.en = exec && (op == OP_LDST);
  assign mem_req.wr = fn;
  assign mem_req.addr = regs[ru][addr_w-1:0];
  assign mem_req.data = regs[rs];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= EXE_RUN;
      pc <= SYM_RESET;
      sp <= '0;
      flag_eq <= 1'b0;
      flag_gt <= 1'b0;
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        EXE_RUN: begin
          if (pc == SYM_ERR) begin
            state <= EXE_HALT;
            busy <= 1'b1;
          end else begin
            pc <= pc_nxt;
            if (is_push) sp <= sp + 1'b1;
            if (is_pop) sp <= sp_m1;
            // Flags only from the .F form
            if (op == OP_ADDSUB && !dst_en) begin
              flag_eq <= (res_x == '0);
              flag_gt <= !res_x[word_w] && (res_x != '0);
            end
            if (op == OP_WAITEMIT) begin
              if (fn) begin
                done <= 1'b1;
                busy <= 1'b0;
              end else begin
                state <= EXE_AWAIT;
              end
            end
          end
        end
        // pc already points past AWAIT
        EXE_AWAIT: begin
          if (start) begin
            state <= EXE_RUN;
            busy <= 1'b1;
          end
        end
        EXE_HALT: busy <= 1'b1;
        default: state <= EXE_HALT;
      endcase
    end
  end

  // Recursion depth stays within the stack
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    is_push |-> (sp != sp_t'(STACK_DEPTH)));
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    is_pop |-> (sp != '0));
  // A ROM hole or a bad return address lands here
  a_no_err: assert property (@(posedge clk) disable iff (!rst_n)
    pc != SYM_ERR);

endmodule

// ==== logic/qs_srt_data_ram.sv ====
`timescale 1ns/1ns

module qs_srt_data_ram
  import qs_srt_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic wr_en,
  input addr_t wr_addr,
  input word_t wr_data,
  input addr_t rd_addr,
  output word_t rd_data,
  input mem_req_t mem_req,
  output word_t mem_rdata
);

  word_t mem [N];
  logic eng_wr;

  assign eng_wr = mem_req.en && mem_req.wr;

  // One write port shared by host and engine
  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
    else if (eng_wr) mem[mem_req.addr] <= mem_req.data;
  end

  // Both reads are asynchronous
  assign rd_data = mem[rd_addr];
  assign mem_rdata = mem[mem_req.addr];

  // Host owns the array only while the engine is idle
  a_no_wr_clash: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_en && eng_wr));

endmodule

// ==== logic/qs_srt.sv ====
`timescale 1ns/1ns

module qs_srt
  import qs_srt_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic wr_en,
  input addr_t wr_addr,
  input word_t wr_data,
  input addr_t rd_addr,
  output word_t rd_data,
  input logic start,
  output logic busy,
  output logic done
);

  pc_t pc;
  inst_t inst;
  mem_req_t mem_req;
  word_t mem_rdata;

  qs_srt_exe u_exe (
    .clk(clk),
    .rst_n(rst_n),
    .inst(inst),
    .pc(pc),
    .mem_req(mem_req),
    .mem_rdata(mem_rdata),
    .start(start),
    .busy(busy),
    .done(done)
  );

  qs_srt_ucode_rom u_rom (
    .ra(pc),
    .rout(inst)
  );

  qs_srt_data_ram u_ram (
    .clk(clk),
    .rst_n(rst_n),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .mem_req(mem_req),
    .mem_rdata(mem_rdata)
  );

  // Host must leave the array alone during a sort
  a_no_host_wr_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_en && busy));

endmodule

// ==== tests/qs_srt_tb.sv ====
`timescale 1ns/1ns

module qs_srt_tb
  import qs_srt_pkg::*;
();

  localparam int IDLE_TIMEOUT = 50;
  localparam int DONE_TIMEOUT = 20000;

  logic clk;
  logic rst_n;
  logic wr_en;
  addr_t wr_addr;
  word_t wr_data;
  addr_t rd_addr;
  word_t rd_data;
  logic start;
  logic busy;
  logic done;

  int seed;
  int errors;
  int timeouts;
  int r;
  // Words written to the DUT and their expected sorted order
  word_t stim [N];
  word_t model [N];

  qs_srt dut0 (
    .clk(clk),
    .rst_n(rst_n),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .start(start),
    .busy(busy),
    .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %s expected %0d actual %0d", name, $signed(exp), $signed(act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %s expected %b actual %b", name, exp, act);
    end
  endtask

  // Signed ascending insertion sort of stim into model
  task automatic sort_model();
    word_t key;
    int k;
    for (int i = 0; i < N; i++) model[i] = stim[i];
    for (int i = 1; i < N; i++) begin
      key = model[i];
      k = i - 1;
      while (k >= 0 && $signed(model[k]) > $signed(key)) begin
        model[k + 1] = model[k];
        k--;
      end
      model[k + 1] = key;
    end
  endtask

  // Wait for the engine to park in AWAIT with busy and done low
  task automatic wait_idle(input string name);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      check_bit({name, "_idle_busy"}, 1'b0, busy);
      check_bit({name, "_idle_done"}, 1'b0, done);
    end while (dut0.u_exe.state != EXE_AWAIT && cycles < IDLE_TIMEOUT);
    if (dut0.u_exe.state != EXE_AWAIT) begin
      timeouts++;
      $display("TIMEOUT engine never returned to idle during %s", name);
    end
  endtask

  task automatic load_array();
    for (int i = 0; i < N; i++) begin
      @(posedge clk);
      wr_en <= 1'b1;
      wr_addr <= addr_t'(i);
      wr_data <= stim[i];
    end
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  // Pulse start and wait for the single done pulse
  task automatic sort_and_wait(input string name, input logic extra);
    int cycles;
    logic seen;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_bit({name, "_busy_rise"}, 1'b1, busy);
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < DONE_TIMEOUT) begin
      @(posedge clk);
      // Optional stray start in the middle of the sort
      start <= extra && (cycles == 4);
      @(negedge clk);
      cycles++;
      if (done) seen = 1'b1;
      else check_bit({name, "_busy_sort"}, 1'b1, busy);
    end
    if (!seen) begin
      timeouts++;
      $display("TIMEOUT no done pulse for %s", name);
    end else begin
      check_bit({name, "_busy_at_done"}, 1'b0, busy);
    end
  endtask

  task automatic read_back(input string name);
    for (int i = 0; i < N; i++) begin
      @(posedge clk);
      rd_addr <= addr_t'(i);
      @(negedge clk);
      check_word($sformatf("%s[%0d]", name, i), model[i], rd_data);
      // A start kept from the busy phase would restart the engine here
      check_bit({name, "_read_busy"}, 1'b0, busy);
      check_bit({name, "_read_done"}, 1'b0, done);
    end
  endtask

  // Rounds are skipped once the engine has stopped answering
  task automatic run_sort(input string name, input logic extra);
    if (timeouts == 0) begin
      wait_idle(name);
      load_array();
      sort_model();
      sort_and_wait(name, extra);
      // Second done pulse would show up here
      wait_idle({name, "_after"});
      read_back(name);
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < N; i++) stim[i] = word_t'($random(seed));
  endtask

  task automatic fill_pattern(input int kind);
    word_t same;
    same = word_t'($random(seed));
    for (int i = 0; i < N; i++) begin
      case (kind)
        0: stim[i] = word_t'(i * 3 - 20);
        1: stim[i] = word_t'(100 - i * 13);
        2: stim[i] = same;
        // Few distinct values with negatives among them
        default: stim[i] = word_t'($random(seed) % 3);
      endcase
    end
  endtask

  initial begin
    seed = 9;
    errors = 0;
    timeouts = 0;
    rst_n = 1'b0;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    rd_addr = '0;
    start = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    wait_idle("reset");
    fill_random();
    run_sort("random", 1'b0);
    fill_pattern(0);
    run_sort("sorted", 1'b0);
    fill_pattern(1);
    run_sort("reverse", 1'b0);
    fill_pattern(2);
    run_sort("equal", 1'b0);
    fill_pattern(3);
    run_sort("dups", 1'b0);
    // Back to back rounds with one stray start while busy
    for (r = 0; r < 10; r++) begin
      fill_random();
      run_sort($sformatf("round%0d", r), r == 3);
    end
    $display("errors=%0d timeouts=%0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== qs_srt.f ====
logic/qs_srt_pkg.sv
logic/qs_srt_ucode_rom.sv
logic/qs_srt_exe.sv
logic/qs_srt_data_ram.sv
logic/qs_srt.sv
tests/qs_srt_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the sort engine testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module qs_srt_tb -f qs_srt.f -o qs_srt_sim
status=0
./obj_dir/qs_srt_sim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
